/* lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// Data path and address width
`define LC3B_WORD_W 16

// Register index width and register count
`define LC3B_REG_W 3
`define LC3B_NUM_REGS 8

// First fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// BR with n, z and p all clear, never taken
`define LC3B_NOP_INSTR 16'h0000

`endif

/* lc3b_pkg.sv */
`include "lc3b_defines.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0]  lc3b_reg;
	typedef logic [2:0]              lc3b_nzp;     // n, z, p
	typedef logic [4:0]              lc3b_imm5;
	typedef logic [5:0]              lc3b_offset6; // LDR/STR word offset
	typedef logic [8:0]              lc3b_offset9; // BR word offset

	// ISA encodings of the kept instructions
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass  // Operand b straight through
	} lc3b_aluop;

	// Operand source chosen in decode, applied in EX
	typedef enum logic [1:0] {
		fwd_none,
		fwd_ex_mem,
		fwd_mem_wb
	} lc3b_fwd_sel;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module fetch_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               advance,     // Whole pipeline moves
	input  logic               redirect,    // Taken BR in EX
	input  lc3b_pkg::lc3b_word redirect_pc,
	input  logic               hold,        // Decode interlock
	output lc3b_pkg::lc3b_word pc,          // Also the icache address
	output lc3b_pkg::lc3b_word pc_plus2
);

	assign pc_plus2 = pc + lc3b_pkg::lc3b_word'(2);

	// Redirect beats hold, the held instruction is flushed anyway
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `LC3B_RESET_PC;
		end else if (advance) begin
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!hold) begin
				pc <= pc_plus2;  // Sequential fetch
			end
		end
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module decode_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  advance,
	input  logic                  flush,            // Taken BR in EX
	input  lc3b_pkg::lc3b_word    instr,            // icache read data
	input  lc3b_pkg::lc3b_word    pc_plus2,
	input  logic                  reg_write,        // From MEM_WB
	input  lc3b_pkg::lc3b_reg     write_dest,
	input  lc3b_pkg::lc3b_word    write_data,
	input  logic                  ex_mem_cc_write,
	input  logic                  mem_wb_cc_write,
	output logic                  hold,
	output logic                  id_ex_valid,
	output lc3b_pkg::lc3b_opcode  id_ex_opcode,
	output lc3b_pkg::lc3b_aluop   id_ex_aluop,
	output lc3b_pkg::lc3b_reg     id_ex_dest,       // nzp mask for BR
	output lc3b_pkg::lc3b_word    id_ex_sr1_val,
	output lc3b_pkg::lc3b_word    id_ex_sr2_val,
	output lc3b_pkg::lc3b_word    id_ex_imm,
	output logic                  id_ex_use_imm,
	output lc3b_pkg::lc3b_fwd_sel id_ex_fwd1,
	output lc3b_pkg::lc3b_fwd_sel id_ex_fwd2,
	output lc3b_pkg::lc3b_word    id_ex_store_data,
	output lc3b_pkg::lc3b_word    id_ex_pc
);

	lc3b_pkg::lc3b_word    if_id_instr;
	lc3b_pkg::lc3b_word    if_id_pc;
	logic                  if_id_valid;
	lc3b_pkg::lc3b_opcode  opcode;
	lc3b_pkg::lc3b_reg     dest;
	lc3b_pkg::lc3b_reg     src1;
	lc3b_pkg::lc3b_reg     src2;
	lc3b_pkg::lc3b_imm5    imm5;
	lc3b_pkg::lc3b_offset6 offset6;
	lc3b_pkg::lc3b_offset9 offset9;
	lc3b_pkg::lc3b_aluop   aluop;
	lc3b_pkg::lc3b_word    imm_ext;
	logic                  use_imm;
	logic                  writes;           // Writes a register and cc
	logic                  uses_src1;
	logic                  uses_src2;
	logic                  str_src;          // STR source goes out on port 2
	lc3b_pkg::lc3b_word    regs [`LC3B_NUM_REGS];
	lc3b_pkg::lc3b_word    rd1;
	lc3b_pkg::lc3b_word    rd2;
	logic                  id_ex_writes;
	logic                  id_ex_live;
	lc3b_pkg::lc3b_reg     ex_mem_dest_cp;   // Copy of EX_MEM destination
	logic                  ex_mem_writes_cp;
	logic                  load_use;
	logic                  cc_pending;

	// Newest producer wins
	function automatic lc3b_pkg::lc3b_fwd_sel fwd_for(
		input lc3b_pkg::lc3b_reg src,
		input logic              near_live,
		input lc3b_pkg::lc3b_reg near_dest,
		input logic              far_live,
		input lc3b_pkg::lc3b_reg far_dest
	);
		if (near_live && near_dest == src) begin
			return lc3b_pkg::fwd_ex_mem;
		end else if (far_live && far_dest == src) begin
			return lc3b_pkg::fwd_mem_wb;
		end
		return lc3b_pkg::fwd_none;
	endfunction

	// IF_ID register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id_valid <= 1'b0;
			if_id_instr <= `LC3B_NOP_INSTR;
		end else if (advance) begin
			if (flush) begin
				if_id_valid <= 1'b0;
				if_id_instr <= `LC3B_NOP_INSTR;  // Wrong-path fetch dropped
			end else if (!hold) begin
				if_id_valid <= 1'b1;
				if_id_instr <= instr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !hold) begin
			if_id_pc <= pc_plus2;
		end
	end

	// Instruction fields
	assign opcode  = lc3b_pkg::lc3b_opcode'(if_id_instr[15:12]);
	assign dest    = if_id_instr[11:9];
	assign src1    = if_id_instr[8:6];  // SR1 or BaseR
	assign imm5    = if_id_instr[4:0];
	assign offset6 = if_id_instr[5:0];
	assign offset9 = if_id_instr[8:0];
	assign str_src = (opcode == lc3b_pkg::op_str);
	assign src2    = str_src ? if_id_instr[11:9] : if_id_instr[2:0];

	// Control decode
	always_comb begin
		aluop     = lc3b_pkg::alu_pass;
		use_imm   = 1'b0;
		writes    = 1'b0;
		uses_src1 = 1'b0;
		uses_src2 = 1'b0;
		imm_ext   = {{(`LC3B_WORD_W-9){offset9[8]}}, offset9};  // BR offset
		case (opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				aluop     = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add : lc3b_pkg::alu_and;
				use_imm   = if_id_instr[5];  // Immediate form
				writes    = 1'b1;
				uses_src1 = 1'b1;
				uses_src2 = !if_id_instr[5];
				imm_ext   = {{(`LC3B_WORD_W-5){imm5[4]}}, imm5};
			end
			lc3b_pkg::op_not: begin
				aluop     = lc3b_pkg::alu_not;
				writes    = 1'b1;
				uses_src1 = 1'b1;
			end
			lc3b_pkg::op_ldr, lc3b_pkg::op_str: begin
				aluop     = lc3b_pkg::alu_add;  // Base plus offset
				use_imm   = 1'b1;
				writes    = (opcode == lc3b_pkg::op_ldr);
				uses_src1 = 1'b1;
				uses_src2 = str_src;
				imm_ext   = {{(`LC3B_WORD_W-6){offset6[5]}}, offset6};
			end
			default: begin
			end
		endcase
	end

	// Register file, written from MEM_WB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (advance && reg_write) begin
			regs[write_dest] <= write_data;
		end
	end

	// Write-through so ID sees this cycle's writeback
	assign rd1 = (reg_write && write_dest == src1) ? write_data : regs[src1];
	assign rd2 = (reg_write && write_dest == src2) ? write_data : regs[src2];

	// Interlocks
	assign id_ex_live = id_ex_valid && id_ex_writes;
	assign load_use   = if_id_valid && id_ex_valid && (id_ex_opcode == lc3b_pkg::op_ldr) &&
	                    ((uses_src1 && src1 == id_ex_dest) || (uses_src2 && src2 == id_ex_dest));
	assign cc_pending = if_id_valid && (opcode == lc3b_pkg::op_br) &&
	                    (id_ex_live || ex_mem_cc_write || mem_wb_cc_write);
	assign hold       = load_use || cc_pending;

	// ID_EX control, bubble on hold or flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_valid      <= 1'b0;
			id_ex_writes     <= 1'b0;
			ex_mem_writes_cp <= 1'b0;
		end else if (advance) begin
			id_ex_valid      <= if_id_valid && !flush && !hold;
			id_ex_writes     <= writes;
			ex_mem_writes_cp <= id_ex_live;  // Follows ID_EX into EX_MEM
		end
	end

	// ID_EX payload, meaningless while id_ex_valid is low
	always_ff @(posedge clk) begin
		if (advance) begin
			id_ex_opcode     <= opcode;
			id_ex_aluop      <= aluop;
			id_ex_dest       <= dest;
			id_ex_sr1_val    <= rd1;
			id_ex_sr2_val    <= rd2;
			id_ex_imm        <= imm_ext;
			id_ex_use_imm    <= use_imm;
			id_ex_store_data <= rd2;  // STR source when str_src
			id_ex_pc         <= if_id_pc;
			id_ex_fwd1       <= fwd_for(src1, id_ex_live, id_ex_dest, ex_mem_writes_cp,
			                            ex_mem_dest_cp);
			id_ex_fwd2       <= fwd_for(src2, id_ex_live, id_ex_dest, ex_mem_writes_cp,
			                            ex_mem_dest_cp);
			ex_mem_dest_cp   <= id_ex_dest;
		end
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  advance,
	input  logic                  id_ex_valid,
	input  lc3b_pkg::lc3b_opcode  id_ex_opcode,
	input  lc3b_pkg::lc3b_aluop   id_ex_aluop,
	input  lc3b_pkg::lc3b_reg     id_ex_dest,
	input  lc3b_pkg::lc3b_word    id_ex_sr1_val,
	input  lc3b_pkg::lc3b_word    id_ex_sr2_val,
	input  lc3b_pkg::lc3b_word    id_ex_imm,
	input  logic                  id_ex_use_imm,
	input  lc3b_pkg::lc3b_fwd_sel id_ex_fwd1,
	input  lc3b_pkg::lc3b_fwd_sel id_ex_fwd2,
	input  lc3b_pkg::lc3b_word    id_ex_store_data,
	input  lc3b_pkg::lc3b_word    id_ex_pc,          // Already PC plus two
	input  lc3b_pkg::lc3b_nzp     cc,
	input  lc3b_pkg::lc3b_word    mem_wb_value,      // Writeback mux output
	output logic                  redirect,
	output lc3b_pkg::lc3b_word    redirect_pc,
	output logic                  ex_mem_valid,
	output lc3b_pkg::lc3b_word    ex_mem_result,
	output lc3b_pkg::lc3b_reg     ex_mem_dest,
	output logic                  ex_mem_wr_reg,
	output logic                  ex_mem_wr_cc,
	output logic                  ex_mem_mem_read,
	output lc3b_pkg::lc3b_word    dcache_address,
	output lc3b_pkg::lc3b_word    dcache_wdata,
	output logic                  dcache_read,
	output logic                  dcache_write
);

	lc3b_pkg::lc3b_word op_a;
	lc3b_pkg::lc3b_word op_b_reg;   // Forwarded register operand
	lc3b_pkg::lc3b_word op_b;
	lc3b_pkg::lc3b_word store_val;
	lc3b_pkg::lc3b_word offset_x2;
	lc3b_pkg::lc3b_word alu_out;
	lc3b_pkg::lc3b_nzp  br_mask;
	logic               is_br;
	logic               is_ldr;
	logic               is_str;
	logic               writes;
	logic               ex_mem_mem_write;
	lc3b_pkg::lc3b_word ex_mem_wdata;

	function automatic lc3b_pkg::lc3b_word fwd_mux(
		input lc3b_pkg::lc3b_fwd_sel sel,
		input lc3b_pkg::lc3b_word    reg_val,
		input lc3b_pkg::lc3b_word    from_ex_mem,
		input lc3b_pkg::lc3b_word    from_mem_wb
	);
		case (sel)
			lc3b_pkg::fwd_ex_mem: return from_ex_mem;
			lc3b_pkg::fwd_mem_wb: return from_mem_wb;
			default:              return reg_val;
		endcase
	endfunction

	assign op_a      = fwd_mux(id_ex_fwd1, id_ex_sr1_val, ex_mem_result, mem_wb_value);
	assign op_b_reg  = fwd_mux(id_ex_fwd2, id_ex_sr2_val, ex_mem_result, mem_wb_value);
	assign store_val = fwd_mux(id_ex_fwd2, id_ex_store_data, ex_mem_result, mem_wb_value);

	assign is_br  = (id_ex_opcode == lc3b_pkg::op_br);
	assign is_ldr = (id_ex_opcode == lc3b_pkg::op_ldr);
	assign is_str = (id_ex_opcode == lc3b_pkg::op_str);
	assign writes = id_ex_opcode inside {lc3b_pkg::op_add, lc3b_pkg::op_and,
	                                     lc3b_pkg::op_not, lc3b_pkg::op_ldr};

	// Word offsets for memory and branch
	assign offset_x2 = id_ex_imm << 1;
	assign op_b      = !id_ex_use_imm        ? op_b_reg  :
	                   (is_ldr || is_str)    ? offset_x2 : id_ex_imm;

	always_comb begin
		case (id_ex_aluop)
			lc3b_pkg::alu_add: alu_out = op_a + op_b;
			lc3b_pkg::alu_and: alu_out = op_a & op_b;
			lc3b_pkg::alu_not: alu_out = ~op_a;
			default:           alu_out = op_b;  // Pass
		endcase
	end

	// Branch test against the committed cc
	assign br_mask     = id_ex_dest;  // nzp bits of BR
	assign redirect    = id_ex_valid && is_br && |(br_mask & cc);
	assign redirect_pc = id_ex_pc + offset_x2;

	// EX_MEM control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_valid     <= 1'b0;
			ex_mem_wr_reg    <= 1'b0;
			ex_mem_wr_cc     <= 1'b0;
			ex_mem_mem_read  <= 1'b0;
			ex_mem_mem_write <= 1'b0;
		end else if (advance) begin
			ex_mem_valid     <= id_ex_valid;
			ex_mem_wr_reg    <= writes;
			ex_mem_wr_cc     <= writes;  // Every register writer sets cc
			ex_mem_mem_read  <= is_ldr;
			ex_mem_mem_write <= is_str;
		end
	end

	// EX_MEM payload
	always_ff @(posedge clk) begin
		if (advance) begin
			ex_mem_result <= alu_out;
			ex_mem_dest   <= id_ex_dest;
			ex_mem_wdata  <= store_val;
		end
	end

	// Data cache request, steady while stalled
	assign dcache_address = ex_mem_result;
	assign dcache_wdata   = ex_mem_wdata;
	assign dcache_read    = ex_mem_valid && ex_mem_mem_read;
	assign dcache_write   = ex_mem_valid && ex_mem_mem_write;

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               advance,
	input  logic               ex_mem_valid,
	input  lc3b_pkg::lc3b_word ex_mem_result,
	input  lc3b_pkg::lc3b_reg  ex_mem_dest,
	input  logic               ex_mem_wr_reg,
	input  logic               ex_mem_wr_cc,
	input  logic               ex_mem_mem_read,
	input  lc3b_pkg::lc3b_word dcache_rdata,
	output logic               reg_write,
	output lc3b_pkg::lc3b_reg  write_dest,
	output lc3b_pkg::lc3b_word write_data,
	output lc3b_pkg::lc3b_nzp  cc,
	output logic               ex_mem_cc_write,   // For the BR interlock
	output logic               mem_wb_cc_write
);

	logic               mem_wb_valid;
	logic               mem_wb_wr_reg;
	logic               mem_wb_wr_cc;
	logic               mem_wb_mem_read;
	lc3b_pkg::lc3b_word mem_wb_result;
	lc3b_pkg::lc3b_word mem_wb_rdata;   // Load data
	lc3b_pkg::lc3b_reg  mem_wb_dest;
	lc3b_pkg::lc3b_nzp  gen_cc;

	// MEM_WB control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb_valid    <= 1'b0;
			mem_wb_wr_reg   <= 1'b0;
			mem_wb_wr_cc    <= 1'b0;
			mem_wb_mem_read <= 1'b0;
		end else if (advance) begin
			mem_wb_valid    <= ex_mem_valid;
			mem_wb_wr_reg   <= ex_mem_wr_reg;
			mem_wb_wr_cc    <= ex_mem_wr_cc;
			mem_wb_mem_read <= ex_mem_mem_read;
		end
	end

	// Advance implies dcache_resp for a pending load
	always_ff @(posedge clk) begin
		if (advance) begin
			mem_wb_result <= ex_mem_result;
			mem_wb_rdata  <= dcache_rdata;
			mem_wb_dest   <= ex_mem_dest;
		end
	end

	assign write_data      = mem_wb_mem_read ? mem_wb_rdata : mem_wb_result;
	assign write_dest      = mem_wb_dest;
	assign reg_write       = mem_wb_valid && mem_wb_wr_reg;
	assign ex_mem_cc_write = ex_mem_valid && ex_mem_wr_cc;
	assign mem_wb_cc_write = mem_wb_valid && mem_wb_wr_cc;

	// nzp of the written value
	always_comb begin
		if ($signed(write_data) < 0) begin
			gen_cc = 3'b100;
		end else if (write_data == '0) begin
			gen_cc = 3'b010;
		end else begin
			gen_cc = 3'b001;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cc <= '0;  // No flag set, BR falls through
		end else if (advance && mem_wb_cc_write) begin
			cc <= gen_cc;
		end
	end

endmodule

/* pipeline_datapath.sv */
`timescale 1ns/1ps

module pipeline_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               icache_resp,
	input  logic               dcache_resp,
	input  lc3b_pkg::lc3b_word icache_rdata,
	input  lc3b_pkg::lc3b_word dcache_rdata,
	output logic               icache_read,
	output logic               dcache_read,
	output logic               dcache_write,
	output lc3b_pkg::lc3b_word icache_address,
	output lc3b_pkg::lc3b_word dcache_address,
	output lc3b_pkg::lc3b_word dcache_wdata
);

	logic                  advance;
	logic                  hold;
	logic                  redirect;           // Also the decode flush
	lc3b_pkg::lc3b_word    redirect_pc;
	lc3b_pkg::lc3b_word    pc_plus2;

	// ID_EX
	logic                  id_ex_valid;
	lc3b_pkg::lc3b_opcode  id_ex_opcode;
	lc3b_pkg::lc3b_aluop   id_ex_aluop;
	lc3b_pkg::lc3b_reg     id_ex_dest;
	lc3b_pkg::lc3b_word    id_ex_sr1_val;
	lc3b_pkg::lc3b_word    id_ex_sr2_val;
	lc3b_pkg::lc3b_word    id_ex_imm;
	logic                  id_ex_use_imm;
	lc3b_pkg::lc3b_fwd_sel id_ex_fwd1;
	lc3b_pkg::lc3b_fwd_sel id_ex_fwd2;
	lc3b_pkg::lc3b_word    id_ex_store_data;
	lc3b_pkg::lc3b_word    id_ex_pc;

	// EX_MEM
	logic                  ex_mem_valid;
	lc3b_pkg::lc3b_word    ex_mem_result;
	lc3b_pkg::lc3b_reg     ex_mem_dest;
	logic                  ex_mem_wr_reg;
	logic                  ex_mem_wr_cc;
	logic                  ex_mem_mem_read;

	// Writeback results
	logic                  reg_write;
	lc3b_pkg::lc3b_reg     write_dest;
	lc3b_pkg::lc3b_word    write_data;
	lc3b_pkg::lc3b_nzp     cc;
	logic                  ex_mem_cc_write;
	logic                  mem_wb_cc_write;

	// Instruction fetch never idles
	assign icache_read = 1'b1;

	// Any missing cache response freezes every stage
	assign advance = icache_resp && (!(dcache_read || dcache_write) || dcache_resp);

	fetch_stage u_fetch (
		.pc (icache_address),
		.*
	);

	decode_stage u_decode (
		.instr (icache_rdata),
		.flush (redirect),
		.*
	);

	execute_stage u_execute (
		.mem_wb_value (write_data),
		.*
	);

	writeback_stage u_writeback (
		.*
	);

endmodule

/* tb_pipeline_datapath.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module tb_pipeline_datapath;

	localparam int NUM_PROGS  = 12;
	localparam int BODY_LEN   = 48;              // Random instructions per program
	localparam int HALT_IDX   = BODY_LEN + 8;    // Word index of the branch-to-self
	localparam int PROG_LEN   = HALT_IDX + 1;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 32768;
	localparam int CLK_PERIOD = 40;
	// Twice the roughly 8 cycles an instruction takes with slow caches
	localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 16 + 10);

	logic               clk;
	logic               rst_n;
	logic               icache_resp;
	logic               dcache_resp;
	lc3b_pkg::lc3b_word icache_rdata;
	lc3b_pkg::lc3b_word dcache_rdata;
	logic               icache_read;
	logic               dcache_read;
	logic               dcache_write;
	lc3b_pkg::lc3b_word icache_address;
	lc3b_pkg::lc3b_word dcache_address;
	lc3b_pkg::lc3b_word dcache_wdata;

	lc3b_pkg::lc3b_word imem [IMEM_WORDS];
	lc3b_pkg::lc3b_word dmem [DMEM_WORDS];
	lc3b_pkg::lc3b_word ref_mem [DMEM_WORDS];  // Data memory as the reference sees it
	lc3b_pkg::lc3b_word exp_addr [$];
	lc3b_pkg::lc3b_word exp_data [$];
	int                 iwait;               // Cycles left before icache_resp
	int                 dwait;
	logic               ifresh;              // Next cycle starts a new request
	logic               dfresh;
	logic               moves;               // Pipeline advances at the coming edge
	logic               wr_waiting;
	lc3b_pkg::lc3b_word prev_addr;
	lc3b_pkg::lc3b_word prev_wdata;
	int                 fail_count;
	int unsigned        seed_ret;

	pipeline_datapath DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Initial data word with every address bit mixed in
	function automatic lc3b_pkg::lc3b_word fill_word(input int idx);
		return 16'(idx * 40503) ^ 16'hc3a5 ^ 16'(idx >> 7);
	endfunction

	task automatic check_value(input string name, input lc3b_pkg::lc3b_word got,
	                           input lc3b_pkg::lc3b_word exp);
		if (got !== exp) begin
			fail_count++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Mostly recent destinations to build dependence chains
	function automatic lc3b_pkg::lc3b_reg pick_src(input lc3b_pkg::lc3b_reg last,
	                                               input lc3b_pkg::lc3b_reg older);
		int unsigned r;
		r = $urandom % 4;
		if (r == 0) begin
			return last;
		end else if (r == 1) begin
			return older;
		end
		return 3'($urandom);
	endfunction

	task automatic build_program();
		lc3b_pkg::lc3b_reg  dr;
		lc3b_pkg::lc3b_reg  last;
		lc3b_pkg::lc3b_reg  older;
		lc3b_pkg::lc3b_word w;
		int unsigned        kind;
		int unsigned        span;
		last  = 3'd0;
		older = 3'd1;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = `LC3B_NOP_INSTR;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
		end
		for (int i = 0; i < BODY_LEN; i++) begin
			dr   = 3'($urandom);
			kind = $urandom % 8;
			case (kind)
				0: w = {4'b0001, dr, pick_src(last, older), 3'b000, pick_src(last, older)};
				1: w = {4'b0001, dr, pick_src(last, older), 1'b1, 5'($urandom)};
				2: w = {4'b0101, dr, pick_src(last, older), 3'b000, pick_src(last, older)};
				3: w = {4'b0101, dr, pick_src(last, older), 1'b1, 5'($urandom)};
				4: w = {4'b1001, dr, pick_src(last, older), 6'b111111};
				5: w = {4'b0110, dr, pick_src(last, older), 6'($urandom)};  // LDR
				6: w = {4'b0111, pick_src(last, older), pick_src(last, older), 6'($urandom)};
				default: begin
					span = BODY_LEN - 1 - i;  // Target stays ahead of the final stores
					if (span > 3) begin
						span = 3;
					end
					w = {4'b0000, 3'($urandom), 9'($urandom % (span + 1))};
				end
			endcase
			imem[i] = w;
			if (kind <= 5) begin
				older = last;
				last  = dr;
			end
		end
		for (int k = 0; k < `LC3B_NUM_REGS; k++) begin
			imem[BODY_LEN + k] = {4'b0111, 3'(k), 3'd0, 6'(k)};  // STR rk, r0, #k
		end
		imem[HALT_IDX] = {4'b0000, 3'b111, 9'h1ff};  // BRnzp to itself
	endtask

	// Architectural run of imem that fills the expected store queues
	function automatic void run_reference();
		lc3b_pkg::lc3b_word r [`LC3B_NUM_REGS];
		lc3b_pkg::lc3b_nzp  cc;
		lc3b_pkg::lc3b_word ir;
		lc3b_pkg::lc3b_word a;
		lc3b_pkg::lc3b_word b;
		lc3b_pkg::lc3b_word res;
		lc3b_pkg::lc3b_word addr;
		int                 pc;  // Word index
		logic               wr;
		for (int k = 0; k < `LC3B_NUM_REGS; k++) begin
			r[k] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			ref_mem[i] = fill_word(i);
		end
		cc = 3'b000;
		pc = 0;
		res = '0;
		exp_addr.delete();
		exp_data.delete();
		while (pc != HALT_IDX) begin
			ir   = imem[pc];
			pc   = pc + 1;
			wr   = 1'b0;
			a    = r[ir[8:6]];
			b    = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};  // Base plus offset words
			case (ir[15:12])
				4'b0001: begin
					res = a + b;
					wr  = 1'b1;
				end
				4'b0101: begin
					res = a & b;
					wr  = 1'b1;
				end
				4'b1001: begin
					res = ~a;
					wr  = 1'b1;
				end
				4'b0110: begin
					res = ref_mem[addr[15:1]];
					wr  = 1'b1;
				end
				4'b0111: begin
					ref_mem[addr[15:1]] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
				end
				default: begin
					if ((ir[11:9] & cc) != 3'b000) begin
						pc = pc + $signed(ir[8:0]);
					end
				end
			endcase
			if (wr) begin
				r[ir[11:9]] = res;
				cc = res[15] ? 3'b100 : (res == '0) ? 3'b010 : 3'b001;
			end
		end
	endfunction

	// Cache models answer each request 0 to 3 cycles late
	always @(posedge clk) begin
		#2;
		if (ifresh) begin
			iwait  = $urandom % 4;
			ifresh = 1'b0;
		end
		icache_resp  = (iwait == 0);
		icache_rdata = imem[icache_address[8:1]];
		if (iwait != 0) begin
			iwait--;
		end
		if (dcache_read || dcache_write) begin
			if (dfresh) begin
				dwait  = $urandom % 4;
				dfresh = 1'b0;
			end
			dcache_resp = (dwait == 0);
			if (dwait != 0) begin
				dwait--;
			end
		end else begin
			dcache_resp = 1'b0;
			dfresh      = 1'b1;
		end
		dcache_rdata = dmem[dcache_address[15:1]];
		moves = icache_resp && (!(dcache_read || dcache_write) || dcache_resp);
		if (moves) begin
			ifresh = 1'b1;
		end
		if (moves && dcache_resp) begin
			dfresh = 1'b1;
			if (dcache_write) begin
				dmem[dcache_address[15:1]] = dcache_wdata;
			end
		end
	end

	// Store checker runs mid-cycle when everything has settled
	always @(negedge clk) begin
		if (!rst_n) begin
			wr_waiting = 1'b0;
		end else begin
			check_value("icache_read", icache_read, 16'd1);  // Fetch never idles
			if (wr_waiting) begin  // Request must hold until answered
				check_value("dcache_write", dcache_write, 16'd1);
				check_value("dcache_address", dcache_address, prev_addr);
				check_value("dcache_wdata", dcache_wdata, prev_wdata);
			end
			if (dcache_write && moves) begin
				if (exp_addr.size() == 0) begin
					$display("Store of %h to %h when no store was expected",
					         dcache_wdata, dcache_address);
					$display("Some tests failed");
					$fatal(1, "Unexpected store");
				end
				check_value("dcache_address", dcache_address, exp_addr.pop_front());
				check_value("dcache_wdata", dcache_wdata, exp_data.pop_front());
			end
			wr_waiting = dcache_write && !moves;
			prev_addr  = dcache_address;
			prev_wdata = dcache_wdata;
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Some tests failed");
		$fatal(1, "Watchdog expired with %0d stores still expected", exp_addr.size());
	end

	initial begin
		seed_ret     = $urandom(32'h62f9a61c);
		clk          = 1'b0;
		rst_n        = 1'b0;
		icache_resp  = 1'b0;
		dcache_resp  = 1'b0;
		icache_rdata = '0;
		dcache_rdata = '0;
		iwait        = 0;
		dwait        = 0;
		ifresh       = 1'b1;
		dfresh       = 1'b1;
		moves        = 1'b0;
		wr_waiting   = 1'b0;
		prev_addr    = '0;
		prev_wdata   = '0;
		fail_count   = 0;
		for (int prog = 0; prog < NUM_PROGS; prog++) begin
			@(posedge clk);
			#2;
			rst_n = 1'b0;
			build_program();
			run_reference();
			repeat (5) @(posedge clk);
			#2;
			rst_n = 1'b1;
			@(negedge clk);
			check_value("icache_address", icache_address, `LC3B_RESET_PC);
			check_value("dcache_read", dcache_read, 16'd0);
			check_value("dcache_write", dcache_write, 16'd0);
			while (exp_addr.size() != 0) begin
				@(negedge clk);
			end
		end
		if (fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
lc3b_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
pipeline_datapath.sv
tb_pipeline_datapath.sv

/* Bender.yml */
package:
  name: lc3b_pipeline

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lc3b_pkg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - execute_stage.sv
      - writeback_stage.sv
      - pipeline_datapath.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_pipeline_datapath.sv
